//--- hw/axil_scratch_pkg.sv
package axil_scratch_pkg;

  localparam int data_width_lp       = 32;
  localparam int addr_width_lp       = 32;
  localparam int mask_width_lp       = data_width_lp / 8;
  localparam int mem_words_lp        = 16;
  localparam int word_index_width_lp = $clog2(mem_words_lp);

  typedef enum logic [1:0] {
    e_axi_resp_okay   = 2'b00,
    e_axi_resp_exokay = 2'b01,
    e_axi_resp_slverr = 2'b10,
    e_axi_resp_decerr = 2'b11
  } axi_resp_e;

  // Bit 0 privileged, bit 1 non-secure, bit 2 instruction
  typedef enum logic [2:0] {
    e_axi_prot_data_secure_unpriv   = 3'b000,
    e_axi_prot_data_secure_priv     = 3'b001,
    e_axi_prot_data_nsecure_unpriv  = 3'b010,
    e_axi_prot_data_nsecure_priv    = 3'b011,
    e_axi_prot_instr_secure_unpriv  = 3'b100,
    e_axi_prot_instr_secure_priv    = 3'b101,
    e_axi_prot_instr_nsecure_unpriv = 3'b110,
    e_axi_prot_instr_nsecure_priv   = 3'b111
  } axi_prot_e;

  // Whole word or individual byte lanes
  typedef union packed {
    logic [data_width_lp-1:0]     word;
    logic [mask_width_lp-1:0][7:0] bytes;
  } scratch_word_u;

endpackage

//--- hw/axil_read_capture.sv
`timescale 1ns/1ps

module axil_read_capture
  import axil_scratch_pkg::*;
  (input                            clk_i
   , input                          reset_i

   // AXI read address beat
   , input [addr_width_lp-1:0]      araddr_i
   , input                          arvalid_i
   , output logic                   arready_o

   // Held address toward the sequencer
   , output logic [addr_width_lp-1:0] addr_o
   , output logic                   v_o
   , input                          yumi_i
  );

  logic                     full_r;
  logic [addr_width_lp-1:0] addr_r;
  logic                     accept;

  // Only an empty entry takes a new beat
  assign arready_o = ~full_r;
  assign accept    = arvalid_i & ~full_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (accept) begin
      full_r <= 1'b1;
    end else if (yumi_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_r <= araddr_i;
    end
  end

  assign addr_o = addr_r;
  assign v_o    = full_r;

endmodule

//--- hw/axil_write_capture.sv
`timescale 1ns/1ps

module axil_write_capture
  import axil_scratch_pkg::*;
  (input                              clk_i
   , input                            reset_i

   // AXI write address beat
   , input [addr_width_lp-1:0]        awaddr_i
   , input                            awvalid_i
   , output logic                     awready_o

   // AXI write data beat
   , input scratch_word_u             wdata_i
   , input [mask_width_lp-1:0]        wstrb_i
   , input                            wvalid_i
   , output logic                     wready_o

   // Paired write toward the sequencer
   , output logic [addr_width_lp-1:0] addr_o
   , output scratch_word_u            data_o
   , output logic [mask_width_lp-1:0] wmask_o
   , output logic                     v_o
   , input                            yumi_i
  );

  logic                     aw_full_r;
  logic [addr_width_lp-1:0] awaddr_r;
  logic                     aw_accept;

  logic                     w_full_r;
  scratch_word_u            wdata_r;
  logic [mask_width_lp-1:0] wmask_r;
  logic                     w_accept;

  assign awready_o = ~aw_full_r;
  assign wready_o  = ~w_full_r;
  assign aw_accept = awvalid_i & ~aw_full_r;
  assign w_accept  = wvalid_i & ~w_full_r;

  // AW and W fill independently, yumi drains both at once
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_full_r <= 1'b0;
      w_full_r  <= 1'b0;
    end else begin
      if (aw_accept) begin
        aw_full_r <= 1'b1;
      end else if (yumi_i) begin
        aw_full_r <= 1'b0;
      end
      if (w_accept) begin
        w_full_r <= 1'b1;
      end else if (yumi_i) begin
        w_full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_accept) begin
      awaddr_r <= awaddr_i;
    end
    if (w_accept) begin
      wdata_r <= wdata_i;
      wmask_r <= wstrb_i;
    end
  end

  assign addr_o  = awaddr_r;
  assign data_o  = wdata_r;
  assign wmask_o = wmask_r;
  assign v_o     = aw_full_r & w_full_r;

endmodule

//--- hw/axil_request_sequencer.sv
`timescale 1ns/1ps

module axil_request_sequencer
  import axil_scratch_pkg::*;
  (input                                    clk_i
   , input                                  reset_i

   // Held read from the read capture
   , input [addr_width_lp-1:0]              rd_addr_i
   , input                                  rd_v_i
   , output logic                           rd_yumi_o

   // Paired write from the write capture
   , input [addr_width_lp-1:0]              wr_addr_i
   , input scratch_word_u                   wr_data_i
   , input [mask_width_lp-1:0]              wr_mask_i
   , input                                  wr_v_i
   , output logic                           wr_yumi_o

   // Memory request
   , output logic [word_index_width_lp-1:0] req_addr_o
   , output scratch_word_u                  req_data_o
   , output logic [mask_width_lp-1:0]       req_mask_o
   , output logic                           req_w_o
   , output logic                           req_v_o
   , input                                  req_ready_and_i

   // Memory response
   , input scratch_word_u                   resp_data_i
   , input                                  resp_v_i
   , output logic                           resp_ready_and_o

   // AXI R and B channels
   , output scratch_word_u                  rdata_o
   , output axi_resp_e                      rresp_o
   , output logic                           rvalid_o
   , input                                  rready_i
   , output axi_resp_e                      bresp_o
   , output logic                           bvalid_o
   , input                                  bready_i
  );

  typedef enum logic [1:0] {e_idle, e_read_wait, e_write_wait} state_e;

  state_e state_r, state_n;
  logic   is_idle;
  logic   is_read_wait;
  logic   is_write_wait;
  logic   resp_done;

  assign is_idle       = (state_r == e_idle);
  assign is_read_wait  = (state_r == e_read_wait);
  assign is_write_wait = (state_r == e_write_wait);

  // Reads win whenever one is held
  assign rd_yumi_o = is_idle & req_ready_and_i & rd_v_i;
  assign wr_yumi_o = is_idle & req_ready_and_i & ~rd_v_i & wr_v_i;

  // Byte address to word index
  assign req_addr_o = rd_v_i ? rd_addr_i[word_index_width_lp+1:2]
                             : wr_addr_i[word_index_width_lp+1:2];
  assign req_data_o = wr_data_i;
  assign req_mask_o = wr_mask_i;
  assign req_w_o    = ~rd_v_i;
  assign req_v_o    = is_idle & (rd_v_i | wr_v_i);

  // AXI back-pressure straight through to the memory
  assign resp_ready_and_o = (is_read_wait & rready_i) | (is_write_wait & bready_i);
  assign resp_done        = resp_v_i & resp_ready_and_o;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (rd_yumi_o) begin
          state_n = e_read_wait;
        end else if (wr_yumi_o) begin
          state_n = e_write_wait;
        end
      end
      default: begin
        if (resp_done) begin
          state_n = e_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

  assign rdata_o  = resp_data_i;
  assign rresp_o  = e_axi_resp_okay;
  assign bresp_o  = e_axi_resp_okay;
  assign rvalid_o = is_read_wait & resp_v_i;
  assign bvalid_o = is_write_wait & resp_v_i;

endmodule

//--- hw/scratch_memory.sv
`timescale 1ns/1ps

module scratch_memory
  import axil_scratch_pkg::*;
  (input                               clk_i
   , input                             reset_i

   // Request
   , input [word_index_width_lp-1:0]   addr_i
   , input scratch_word_u              data_i
   , input [mask_width_lp-1:0]         wmask_i
   , input                             w_i
   , input                             v_i
   , output logic                      ready_and_o

   // Response
   , output scratch_word_u             data_o
   , output logic                      v_o
   , input                             resp_ready_and_i
  );

  scratch_word_u mem_r [mem_words_lp];
  scratch_word_u resp_data_r;
  logic          resp_v_r;
  logic          req_accept;
  logic          resp_taken;

  // No new request until the response slot drains
  assign ready_and_o = ~resp_v_r;
  assign req_accept  = v_i & ~resp_v_r;
  assign resp_taken  = resp_v_r & resp_ready_and_i;

  // Byte lanes update only where the mask is set
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_words_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (req_accept & w_i) begin
      for (int b = 0; b < mask_width_lp; b++) begin
        if (wmask_i[b]) begin
          mem_r[addr_i].bytes[b] <= data_i.bytes[b];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else if (req_accept) begin
      resp_v_r <= 1'b1;
    end else if (resp_taken) begin
      resp_v_r <= 1'b0;
    end
  end

  // Stored word as it was before this request
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      resp_data_r <= mem_r[addr_i];
    end
  end

  assign data_o = resp_data_r;
  assign v_o    = resp_v_r;

endmodule

//--- hw/axil_scratch_top.sv
`timescale 1ns/1ps

module axil_scratch_top
  import axil_scratch_pkg::*;
  (input                                clk_i
   , input                              reset_i

   // Read address channel
   , input [addr_width_lp-1:0]          s_axil_araddr_i
   , input axi_prot_e                   s_axil_arprot_i
   , input                              s_axil_arvalid_i
   , output logic                       s_axil_arready_o

   // Write address channel
   , input [addr_width_lp-1:0]          s_axil_awaddr_i
   , input axi_prot_e                   s_axil_awprot_i
   , input                              s_axil_awvalid_i
   , output logic                       s_axil_awready_o

   // Write data channel
   , input scratch_word_u               s_axil_wdata_i
   , input [mask_width_lp-1:0]          s_axil_wstrb_i
   , input                              s_axil_wvalid_i
   , output logic                       s_axil_wready_o

   // Read data channel
   , output scratch_word_u              s_axil_rdata_o
   , output axi_resp_e                  s_axil_rresp_o
   , output logic                       s_axil_rvalid_o
   , input                              s_axil_rready_i

   // Write response channel
   , output axi_resp_e                  s_axil_bresp_o
   , output logic                       s_axil_bvalid_o
   , input                              s_axil_bready_i
  );

  // Protection fields are accepted and not acted on

  logic [addr_width_lp-1:0]       araddr_li;
  logic                           araddr_v_li;
  logic                           araddr_yumi_lo;

  logic [addr_width_lp-1:0]       awaddr_li;
  scratch_word_u                  wdata_li;
  logic [mask_width_lp-1:0]       wmask_li;
  logic                           write_v_li;
  logic                           write_yumi_lo;

  logic [word_index_width_lp-1:0] req_addr_lo;
  scratch_word_u                  req_data_lo;
  logic [mask_width_lp-1:0]       req_mask_lo;
  logic                           req_w_lo;
  logic                           req_v_lo;
  logic                           req_ready_and_li;

  scratch_word_u                  resp_data_li;
  logic                           resp_v_li;
  logic                           resp_ready_and_lo;

  axil_read_capture u_read_capture
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.araddr_i(s_axil_araddr_i)
     ,.arvalid_i(s_axil_arvalid_i)
     ,.arready_o(s_axil_arready_o)
     ,.addr_o(araddr_li)
     ,.v_o(araddr_v_li)
     ,.yumi_i(araddr_yumi_lo)
     );

  axil_write_capture u_write_capture
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.awaddr_i(s_axil_awaddr_i)
     ,.awvalid_i(s_axil_awvalid_i)
     ,.wdata_i(s_axil_wdata_i)
     ,.wstrb_i(s_axil_wstrb_i)
     ,.wvalid_i(s_axil_wvalid_i)
     ,.yumi_i(write_yumi_lo)
     ,.awready_o(s_axil_awready_o)
     ,.wready_o(s_axil_wready_o)
     ,.addr_o(awaddr_li)
     ,.data_o(wdata_li)
     ,.wmask_o(wmask_li)
     ,.v_o(write_v_li)
     );

  axil_request_sequencer u_sequencer
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.rd_addr_i(araddr_li)
     ,.rd_v_i(araddr_v_li)
     ,.rd_yumi_o(araddr_yumi_lo)
     ,.wr_addr_i(awaddr_li)
     ,.wr_data_i(wdata_li)
     ,.wr_mask_i(wmask_li)
     ,.wr_v_i(write_v_li)
     ,.wr_yumi_o(write_yumi_lo)
     ,.req_addr_o(req_addr_lo)
     ,.req_data_o(req_data_lo)
     ,.req_mask_o(req_mask_lo)
     ,.req_w_o(req_w_lo)
     ,.req_v_o(req_v_lo)
     ,.req_ready_and_i(req_ready_and_li)
     ,.resp_data_i(resp_data_li)
     ,.resp_v_i(resp_v_li)
     ,.resp_ready_and_o(resp_ready_and_lo)
     ,.rdata_o(s_axil_rdata_o)
     ,.rresp_o(s_axil_rresp_o)
     ,.rvalid_o(s_axil_rvalid_o)
     ,.rready_i(s_axil_rready_i)
     ,.bresp_o(s_axil_bresp_o)
     ,.bvalid_o(s_axil_bvalid_o)
     ,.bready_i(s_axil_bready_i)
     );

  scratch_memory u_memory
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.addr_i(req_addr_lo)
     ,.data_i(req_data_lo)
     ,.wmask_i(req_mask_lo)
     ,.w_i(req_w_lo)
     ,.v_i(req_v_lo)
     ,.ready_and_o(req_ready_and_li)
     ,.data_o(resp_data_li)
     ,.v_o(resp_v_li)
     ,.resp_ready_and_i(resp_ready_and_lo)
     );

endmodule

//--- testbench/axil_scratch_assertions.sv
`timescale 1ns/1ps

module axil_scratch_assertions
  import axil_scratch_pkg::*;
  (input                  clk_i
   , input                reset_i
   , input scratch_word_u rdata_i
   , input                rvalid_i
   , input                rready_i
   , input                bvalid_i
   , input                bready_i
  );

  // Only one transaction is in flight, so R and B never overlap
  one_response: assert property (@(posedge clk_i) disable iff (reset_i)
    !(rvalid_i && bvalid_i))
    else $error("rvalid and bvalid high on the same cycle");

  rdata_held: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("R beat changed while rready was low");

  bvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("B beat dropped while bready was low");

endmodule

bind axil_scratch_top axil_scratch_assertions u_assertions
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.rdata_i(s_axil_rdata_o)
   ,.rvalid_i(s_axil_rvalid_o)
   ,.rready_i(s_axil_rready_i)
   ,.bvalid_i(s_axil_bvalid_o)
   ,.bready_i(s_axil_bready_i)
   );

//--- testbench/axil_scratch_tb.sv
`timescale 1ns/1ps

module axil_scratch_tb
  import axil_scratch_pkg::*;
  ();

  localparam int          timeout_lp    = 64;
  localparam int          random_ops_lp = 48;
  localparam logic [31:0] lfsr_taps_lp  = 32'h8020_0003;

  localparam int op_read      = 0;
  localparam int op_write     = 1;
  // AR, AW and W all on one cycle
  localparam int op_both      = 2;
  localparam int ord_same     = 0;
  localparam int ord_aw_first = 1;
  localparam int ord_w_first  = 2;

  typedef struct {
    int          op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    int          order;
    int          stall;
  } step_t;

  localparam int num_steps_lp = 14;
  step_t steps [num_steps_lp] = '{
    '{op_read,  32'h0000_0000, 32'h0000_0000, 4'h0, ord_same,     0},
    '{op_read,  32'h0000_003c, 32'h0000_0000, 4'h0, ord_same,     1},
    '{op_write, 32'h0000_0004, 32'hdead_beef, 4'hf, ord_same,     0},
    '{op_read,  32'h0000_0004, 32'h0000_0000, 4'h0, ord_same,     0},
    '{op_write, 32'h0000_0004, 32'h1122_3344, 4'h5, ord_aw_first, 2},
    '{op_read,  32'h0000_0004, 32'h0000_0000, 4'h0, ord_same,     0},
    '{op_write, 32'h0000_0008, 32'ha5a5_a5a5, 4'h8, ord_w_first,  0},
    '{op_write, 32'h0000_0048, 32'h0bad_f00d, 4'h3, ord_aw_first, 3},
    '{op_read,  32'h0000_0008, 32'h0000_0000, 4'h0, ord_same,     4},
    '{op_write, 32'h0000_0010, 32'h0102_0304, 4'hf, ord_w_first,  0},
    '{op_both,  32'h0000_0010, 32'hcafe_f00d, 4'hf, ord_same,     2},
    '{op_read,  32'h0000_0010, 32'h0000_0000, 4'h0, ord_same,     0},
    '{op_write, 32'h0000_00fc, 32'h7788_99aa, 4'h6, ord_w_first,  5},
    '{op_read,  32'h0000_003c, 32'h0000_0000, 4'h0, ord_same,     3}
  };

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  logic [addr_width_lp-1:0] araddr;
  logic [addr_width_lp-1:0] awaddr;
  axi_prot_e                arprot;
  axi_prot_e                awprot;
  logic                     arvalid;
  logic                     awvalid;
  logic                     wvalid;
  logic                     rready;
  logic                     bready;
  scratch_word_u            wdata;
  logic [mask_width_lp-1:0] wstrb;
  logic                     arready;
  logic                     awready;
  logic                     wready;
  logic                     rvalid;
  logic                     bvalid;
  scratch_word_u            rdata;
  axi_resp_e                rresp;
  axi_resp_e                bresp;

  scratch_word_u            ref_mem [mem_words_lp];
  logic [31:0]              lfsr_state = 32'hdb90;

  always #2 clk_i = ~clk_i;

  axil_scratch_top u_dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.s_axil_araddr_i(araddr)
     ,.s_axil_arprot_i(arprot)
     ,.s_axil_arvalid_i(arvalid)
     ,.s_axil_arready_o(arready)
     ,.s_axil_awaddr_i(awaddr)
     ,.s_axil_awprot_i(awprot)
     ,.s_axil_awvalid_i(awvalid)
     ,.s_axil_awready_o(awready)
     ,.s_axil_wdata_i(wdata)
     ,.s_axil_wstrb_i(wstrb)
     ,.s_axil_wvalid_i(wvalid)
     ,.s_axil_wready_o(wready)
     ,.s_axil_rdata_o(rdata)
     ,.s_axil_rresp_o(rresp)
     ,.s_axil_rvalid_o(rvalid)
     ,.s_axil_rready_i(rready)
     ,.s_axil_bresp_o(bresp)
     ,.s_axil_bvalid_o(bvalid)
     ,.s_axil_bready_i(bready)
     );

  task automatic report_failure();
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_plain(input string what);
    $display("%s at time %0t", what, $time);
    report_failure();
  endtask

  task automatic check_data(input string what, input scratch_word_u got,
                            input scratch_word_u exp);
    if (got.word !== exp.word) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, got.word, exp.word);
      report_failure();
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      report_failure();
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? lfsr_taps_lp : 32'h0);
      r = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic model_write(input logic [31:0] addr, input scratch_word_u data,
                             input logic [3:0] strb);
    for (int b = 0; b < mask_width_lp; b++) begin
      if (strb[b]) begin
        ref_mem[addr[5:2]].bytes[b] = data.bytes[b];
      end
    end
  endtask

  // A valid drops once its ready was seen at the previous falling edge
  task automatic send_beats(input logic do_ar, input logic do_aw, input logic do_w,
                            input logic [31:0] addr, input scratch_word_u data,
                            input logic [3:0] strb);
    logic ar_go;
    logic aw_go;
    logic w_go;
    int   waited;
    araddr  = addr;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    arvalid = do_ar;
    awvalid = do_aw;
    wvalid  = do_w;
    waited  = 0;
    while (arvalid || awvalid || wvalid) begin
      ar_go = arvalid & arready;
      aw_go = awvalid & awready;
      w_go  = wvalid & wready;
      @(negedge clk_i);
      if (ar_go) begin
        arvalid = 1'b0;
      end
      if (aw_go) begin
        awvalid = 1'b0;
      end
      if (w_go) begin
        wvalid = 1'b0;
      end
      waited++;
      if (waited >= timeout_lp) begin
        if (arvalid) begin
          fail_plain("arready never went high");
        end else if (awvalid) begin
          fail_plain("awready never went high");
        end else if (wvalid) begin
          fail_plain("wready never went high");
        end
      end
    end
  endtask

  task automatic take_response(input logic is_read, input scratch_word_u exp, input int stall);
    scratch_word_u held;
    int            waited;
    waited = 0;
    while (!(is_read ? rvalid : bvalid)) begin
      @(negedge clk_i);
      waited++;
      if (waited == timeout_lp) begin
        fail_plain(is_read ? "rvalid never went high" : "bvalid never went high");
      end
    end
    held = rdata;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_i);
      if (!(is_read ? rvalid : bvalid)) begin
        fail_plain("response dropped before it was taken");
      end
      if (is_read) begin
        check_data("stalled rdata", rdata, held);
      end
    end
    if (is_read) begin
      check_data("rdata", held, exp);
      check_resp("rresp", rresp, e_axi_resp_okay);
      rready = 1'b1;
    end else begin
      check_resp("bresp", bresp, e_axi_resp_okay);
      bready = 1'b1;
    end
    @(negedge clk_i);
    rready = 1'b0;
    bready = 1'b0;
    if (rvalid || bvalid) begin
      fail_plain("a response stayed valid after its handshake");
    end
  endtask

  task automatic run_step(input int op, input logic [31:0] addr, input scratch_word_u data,
                          input logic [3:0] strb, input int order, input int stall);
    scratch_word_u old;
    old = ref_mem[addr[5:2]];
    case (op)
      op_read: begin
        send_beats(1'b1, 1'b0, 1'b0, addr, data, strb);
        take_response(1'b1, old, stall);
      end
      op_both: begin
        // Read goes first and still sees the old word
        send_beats(1'b1, 1'b1, 1'b1, addr, data, strb);
        take_response(1'b1, old, stall);
        model_write(addr, data, strb);
        take_response(1'b0, old, stall);
      end
      default: begin
        if (order == ord_aw_first) begin
          send_beats(1'b0, 1'b1, 1'b0, addr, data, strb);
          send_beats(1'b0, 1'b0, 1'b1, addr, data, strb);
        end else if (order == ord_w_first) begin
          send_beats(1'b0, 1'b0, 1'b1, addr, data, strb);
          send_beats(1'b0, 1'b1, 1'b0, addr, data, strb);
        end else begin
          send_beats(1'b0, 1'b1, 1'b1, addr, data, strb);
        end
        model_write(addr, data, strb);
        take_response(1'b0, old, stall);
      end
    endcase
    // A second beat would show one cycle after the handshake
    @(negedge clk_i);
    if (rvalid || bvalid) begin
      fail_plain("an extra response beat followed the last one");
    end
  endtask

  initial begin
    logic [31:0]   r;
    logic [31:0]   addr;
    scratch_word_u data;
    logic [3:0]    strb;
    int            op;
    int            order;
    int            stall;
    reset_i = 1'b1;
    araddr  = '0;
    awaddr  = '0;
    arprot  = e_axi_prot_data_secure_unpriv;
    awprot  = e_axi_prot_data_nsecure_priv;
    arvalid = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    rready  = 1'b0;
    bready  = 1'b0;
    for (int i = 0; i < mem_words_lp; i++) begin
      ref_mem[i] = '0;
    end
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    if (!arready || !awready || !wready) begin
      fail_plain("a channel ready was low after reset");
    end
    if (rvalid || bvalid) begin
      fail_plain("a response was valid after reset");
    end
    for (int i = 0; i < num_steps_lp; i++) begin
      run_step(steps[i].op, steps[i].addr, steps[i].data, steps[i].strb,
               steps[i].order, steps[i].stall);
    end
    // Random mix of reads and writes
    for (int i = 0; i < random_ops_lp; i++) begin
      r = take_bits(1);
      op = r[0] ? op_write : op_read;
      r = take_bits(6);
      addr = {r[29:0], 2'b00};
      data = take_bits(32);
      r = take_bits(4);
      strb = r[3:0];
      r = take_bits(2);
      order = r % 3;
      stall = take_bits(3);
      run_step(op, addr, data, strb, order, stall);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- list.f
hw/axil_scratch_pkg.sv
hw/axil_read_capture.sv
hw/axil_write_capture.sv
hw/axil_request_sequencer.sv
hw/scratch_memory.sv
hw/axil_scratch_top.sv
testbench/axil_scratch_assertions.sv
testbench/axil_scratch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module axil_scratch_tb -o axil_scratch_sim

status=0
output=$(./obj_dir/axil_scratch_sim 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -q "Testbench passed"; then
  exit 0
fi
echo "simulation exit status $status"
exit 1
